//--- verilog/bpu_macros.svh
// Widths and limits for the two-component TAGE predictor
// Changing a width here also changes the hashing and the table sizes
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// Program counter and global history
`define BPU_PC_W        32
`define BPU_GHR_W       12
`define BPU_HIST1_LEN   4
`define BPU_HIST2_LEN   12

// Table geometry
`define BPU_BASE_IDX_W  8
`define BPU_TAG_IDX_W   6
`define BPU_TAG_W       8
`define BPU_N_COMP      2

// Base counter, taken at 2 or more
`define BPU_BASE_W      2
`define BPU_BASE_MAX    3
`define BPU_BASE_INIT   1

// Tagged counter, taken at 4 or more
`define BPU_CTR_W       3
`define BPU_CTR_MAX     7
`define BPU_CTR_WEAK_T  4
`define BPU_CTR_WEAK_NT 3

// Useful counter
`define BPU_U_W         2
`define BPU_U_MAX       3

`endif

//--- verilog/bpu_pkg.sv
// Types shared by the TAGE blocks
// Field widths follow the macros header
`include "bpu_macros.svh"

package bpu_pkg;

    // One word of a tagged component
    typedef struct packed {
        logic                  valid;
        logic [`BPU_TAG_W-1:0] tag;
        logic [`BPU_CTR_W-1:0] ctr;
        logic [`BPU_U_W-1:0]   useful;
    } tage_entry_t;

    // Base bimodal counter
    typedef logic [`BPU_BASE_W-1:0] base_ctr_t;

    // Provider id
    // 0 is base, 1 and 2 are the tagged components, 3 never occurs
    typedef logic [1:0] provider_t;

endpackage

//--- verilog/bpu_if.sv
// Internal TAGE buses, no clock of their own
// Indexes and tags are combinational from the decode stage
`timescale 1ns/1ps
`include "bpu_macros.svh"

// Hashed indexes and tags for the lookup and update paths
interface bpu_lookup_if;
    logic [`BPU_BASE_IDX_W-1:0] lk_base_idx;
    logic [`BPU_TAG_IDX_W-1:0]  lk_idx1;
    logic [`BPU_TAG_W-1:0]      lk_tag1;
    logic [`BPU_TAG_IDX_W-1:0]  lk_idx2;
    logic [`BPU_TAG_W-1:0]      lk_tag2;
    logic [`BPU_BASE_IDX_W-1:0] up_base_idx;
    logic [`BPU_TAG_IDX_W-1:0]  up_idx1;
    logic [`BPU_TAG_W-1:0]      up_tag1;
    logic [`BPU_TAG_IDX_W-1:0]  up_idx2;
    logic [`BPU_TAG_W-1:0]      up_tag2;

    modport decode (output lk_base_idx, lk_idx1, lk_tag1, lk_idx2, lk_tag2,
                    output up_base_idx, up_idx1, up_tag1, up_idx2, up_tag2);
    modport execute (input lk_base_idx, lk_idx1, lk_tag1, lk_idx2, lk_tag2,
                     input up_base_idx, up_idx1, up_tag1, up_idx2, up_tag2);
endinterface

// Update read data out of the tables, write data back in
interface bpu_write_if;
    bpu_pkg::base_ctr_t   rd_base;
    bpu_pkg::tage_entry_t rd_ent1;
    bpu_pkg::tage_entry_t rd_ent2;
    logic [`BPU_TAG_W-1:0] rd_tag1;
    logic [`BPU_TAG_W-1:0] rd_tag2;
    logic                 we_base;
    logic                 we1;
    logic                 we2;
    bpu_pkg::base_ctr_t   wd_base;
    bpu_pkg::tage_entry_t wd_ent1;
    bpu_pkg::tage_entry_t wd_ent2;

    modport tables (output rd_base, rd_ent1, rd_ent2, rd_tag1, rd_tag2,
                    input we_base, we1, we2, wd_base, wd_ent1, wd_ent2);
    modport policy (input rd_base, rd_ent1, rd_ent2, rd_tag1, rd_tag2,
                    output we_base, we1, we2, wd_base, wd_ent1, wd_ent2);
endinterface

//--- verilog/tage_decode.sv
// Global history and hashing, history is non-speculative
// Lookup and update both hash with the history held before this edge
`timescale 1ns/1ps
`include "bpu_macros.svh"

module tage_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  update_valid_i,
    input  logic                  update_taken_i,
    input  logic [`BPU_PC_W-1:0]  predict_pc_i,
    input  logic [`BPU_PC_W-1:0]  update_pc_i,
    bpu_lookup_if.decode          lookup
);

    // PC slices
    localparam int IDX_LSB = 2;
    localparam int TAG_LSB = 8;

    logic [`BPU_GHR_W-1:0] ghr;
    logic [`BPU_TAG_W-1:0] fold1_idx;
    logic [`BPU_TAG_W-1:0] fold2_idx;
    logic [`BPU_TAG_W-1:0] fold1_tag;
    logic [`BPU_TAG_W-1:0] fold2_tag;

    // XOR of w-bit slices from bit 0
    // Bits past len drop out, so the last slice is zero-padded
    function automatic logic [`BPU_TAG_W-1:0] fold_hist(
        input logic [`BPU_GHR_W-1:0] h,
        input int                    len,
        input int                    w
    );
        logic [`BPU_TAG_W-1:0] f;
        f = '0;
        for (int i = 0; i < `BPU_GHR_W; i++) begin
            if (i < len) begin
                f[i % w] = f[i % w] ^ h[i];
            end
        end
        return f;
    endfunction

    // Every resolved branch shifts in, unconditional ones too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr <= '0;
        end else if (update_valid_i) begin
            ghr <= {ghr[`BPU_GHR_W-2:0], update_taken_i};
        end
    end

    // Folds are shared by both paths
    assign fold1_idx = fold_hist(ghr, `BPU_HIST1_LEN, `BPU_TAG_IDX_W);
    assign fold2_idx = fold_hist(ghr, `BPU_HIST2_LEN, `BPU_TAG_IDX_W);
    assign fold1_tag = fold_hist(ghr, `BPU_HIST1_LEN, `BPU_TAG_W);
    assign fold2_tag = fold_hist(ghr, `BPU_HIST2_LEN, `BPU_TAG_W);

    // Lookup path
    assign lookup.lk_base_idx = predict_pc_i[IDX_LSB +: `BPU_BASE_IDX_W];
    assign lookup.lk_idx1 = predict_pc_i[IDX_LSB +: `BPU_TAG_IDX_W]
                          ^ fold1_idx[`BPU_TAG_IDX_W-1:0];
    assign lookup.lk_idx2 = predict_pc_i[IDX_LSB +: `BPU_TAG_IDX_W]
                          ^ fold2_idx[`BPU_TAG_IDX_W-1:0];
    assign lookup.lk_tag1 = predict_pc_i[TAG_LSB +: `BPU_TAG_W] ^ fold1_tag;
    assign lookup.lk_tag2 = predict_pc_i[TAG_LSB +: `BPU_TAG_W] ^ fold2_tag;

    // Update path, same hash on the resolved PC
    assign lookup.up_base_idx = update_pc_i[IDX_LSB +: `BPU_BASE_IDX_W];
    assign lookup.up_idx1 = update_pc_i[IDX_LSB +: `BPU_TAG_IDX_W]
                          ^ fold1_idx[`BPU_TAG_IDX_W-1:0];
    assign lookup.up_idx2 = update_pc_i[IDX_LSB +: `BPU_TAG_IDX_W]
                          ^ fold2_idx[`BPU_TAG_IDX_W-1:0];
    assign lookup.up_tag1 = update_pc_i[TAG_LSB +: `BPU_TAG_W] ^ fold1_tag;
    assign lookup.up_tag2 = update_pc_i[TAG_LSB +: `BPU_TAG_W] ^ fold2_tag;

    // An unknown taken bit would poison every later hash
    a_ghr_known: assert property (@(posedge clk) disable iff (!rst_n)
        update_valid_i |=> !$isunknown(ghr))
        else $error("global history went unknown");

endmodule

//--- verilog/tage_execute.sv
// Tables in flops, one read port per path and one write port per table
// Lookup reads see table state from before a same-cycle update write
`timescale 1ns/1ps
`include "bpu_macros.svh"

module tage_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               predict_req_i,
    bpu_lookup_if.execute      lookup,
    bpu_write_if.tables        wr,
    output logic               predict_valid_o,
    output logic               predict_taken_o,
    output bpu_pkg::provider_t predict_provider_o,
    output logic               predict_alt_taken_o
);

    localparam int BASE_N = 1 << `BPU_BASE_IDX_W;
    localparam int TAG_N  = 1 << `BPU_TAG_IDX_W;
    localparam int NC     = `BPU_N_COMP;

    bpu_pkg::base_ctr_t   base_tbl [BASE_N];
    bpu_pkg::tage_entry_t tag_tbl  [NC][TAG_N];

    // Lookup side
    logic [`BPU_TAG_IDX_W-1:0] lk_idx [NC];
    logic [`BPU_TAG_W-1:0]     lk_tag [NC];
    bpu_pkg::tage_entry_t      lk_ent [NC];
    bpu_pkg::base_ctr_t        lk_base;
    logic [NC-1:0]             hit;
    logic [NC:0]               dir;
    bpu_pkg::provider_t        prov;
    bpu_pkg::provider_t        alt;

    // Prediction registers
    logic               valid_q;
    logic               taken_q;
    logic               alt_taken_q;
    bpu_pkg::provider_t prov_q;

    assign lk_idx[0] = lookup.lk_idx1;
    assign lk_idx[1] = lookup.lk_idx2;
    assign lk_tag[0] = lookup.lk_tag1;
    assign lk_tag[1] = lookup.lk_tag2;

    // Table reads for the lookup
    always_comb begin
        lk_base = base_tbl[lookup.lk_base_idx];
        for (int c = 0; c < NC; c++) begin
            lk_ent[c] = tag_tbl[c][lk_idx[c]];
        end
    end

    // Hit and direction per component, index 0 is base
    always_comb begin
        dir[0] = lk_base[`BPU_BASE_W-1];
        for (int c = 0; c < NC; c++) begin
            hit[c]     = lk_ent[c].valid && (lk_ent[c].tag == lk_tag[c]);
            dir[c + 1] = lk_ent[c].ctr[`BPU_CTR_W-1];
        end
    end

    // Longest hit provides
    // Alternate is the next shorter hit, else base
    always_comb begin
        prov = 2'd0;
        alt  = 2'd0;
        if (hit[1]) begin
            prov = 2'd2;
            if (hit[0]) begin
                alt = 2'd1;
            end
        end else if (hit[0]) begin
            prov = 2'd1;
        end
    end

    // Valid pulses for one cycle per request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= predict_req_i;
        end
    end

    // Data holds until the next request
    always_ff @(posedge clk) begin
        if (predict_req_i) begin
            taken_q     <= dir[prov];
            alt_taken_q <= dir[alt];
            prov_q      <= prov;
        end
    end

    assign predict_valid_o     = valid_q;
    assign predict_taken_o     = taken_q;
    assign predict_alt_taken_o = alt_taken_q;
    assign predict_provider_o  = prov_q;

    // Update side reads, combinational for the policy
    assign wr.rd_base = base_tbl[lookup.up_base_idx];
    assign wr.rd_ent1 = tag_tbl[0][lookup.up_idx1];
    assign wr.rd_ent2 = tag_tbl[1][lookup.up_idx2];
    // Tags for a fresh allocation
    assign wr.rd_tag1 = lookup.up_tag1;
    assign wr.rd_tag2 = lookup.up_tag2;

    // Writes land at the edge ending the update cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BASE_N; i++) begin
                base_tbl[i] <= bpu_pkg::base_ctr_t'(`BPU_BASE_INIT);
            end
            for (int c = 0; c < NC; c++) begin
                for (int i = 0; i < TAG_N; i++) begin
                    tag_tbl[c][i] <= '0;
                end
            end
        end else begin
            if (wr.we_base) begin
                base_tbl[lookup.up_base_idx] <= wr.wd_base;
            end
            if (wr.we1) begin
                tag_tbl[0][lookup.up_idx1] <= wr.wd_ent1;
            end
            if (wr.we2) begin
                tag_tbl[1][lookup.up_idx2] <= wr.wd_ent2;
            end
        end
    end

    // Only base and two components exist
    a_provider_range: assert property (@(posedge clk) disable iff (!rst_n)
        predict_valid_o |-> (predict_provider_o != 2'd3))
        else $error("provider id 3 reported");

endmodule

//--- verilog/tage_result.sv
// Update policy, purely combinational, acts on conditional updates only
// Allocation is deterministic, lowest eligible longer component wins
`timescale 1ns/1ps
`include "bpu_macros.svh"

module tage_result (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               update_valid_i,
    input  logic               update_cond_i,
    input  logic               update_taken_i,
    input  bpu_pkg::provider_t update_provider_i,
    input  logic               update_pred_taken_i,
    input  logic               update_alt_taken_i,
    bpu_write_if.policy        wr
);

    localparam int NC = `BPU_N_COMP;

    bpu_pkg::tage_entry_t  ent     [NC];
    bpu_pkg::tage_entry_t  ent_nxt [NC];
    logic [`BPU_TAG_W-1:0] up_tag  [NC];
    logic [NC-1:0]         we_t;
    logic [NC-1:0]         alloc;
    logic                  act;
    logic                  mispred;
    logic                  correct;
    logic                  found;

    // Saturating counter steps
    function automatic bpu_pkg::base_ctr_t base_train(
        input bpu_pkg::base_ctr_t c,
        input logic               up
    );
        if (up) begin
            return (c == `BPU_BASE_MAX) ? c : c + 1'b1;
        end
        return (c == '0) ? c : c - 1'b1;
    endfunction

    function automatic logic [`BPU_CTR_W-1:0] ctr_train(
        input logic [`BPU_CTR_W-1:0] c,
        input logic                  up
    );
        if (up) begin
            return (c == `BPU_CTR_MAX) ? c : c + 1'b1;
        end
        return (c == '0) ? c : c - 1'b1;
    endfunction

    function automatic logic [`BPU_U_W-1:0] u_step(
        input logic [`BPU_U_W-1:0] u,
        input logic                up
    );
        if (up) begin
            return (u == `BPU_U_MAX) ? u : u + 1'b1;
        end
        return (u == '0) ? u : u - 1'b1;
    endfunction

    assign ent[0]    = wr.rd_ent1;
    assign ent[1]    = wr.rd_ent2;
    assign up_tag[0] = wr.rd_tag1;
    assign up_tag[1] = wr.rd_tag2;

    assign act     = update_valid_i && update_cond_i;
    assign mispred = update_pred_taken_i != update_taken_i;
    assign correct = !mispred;

    always_comb begin
        wr.we_base = 1'b0;
        wr.wd_base = wr.rd_base;
        we_t       = '0;
        alloc      = '0;
        found      = 1'b0;
        for (int c = 0; c < NC; c++) begin
            ent_nxt[c] = ent[c];
        end
        if (act) begin
            // Train the provider
            if (update_provider_i == 2'd0) begin
                wr.wd_base = base_train(wr.rd_base, update_taken_i);
                wr.we_base = 1'b1;
            end
            for (int c = 0; c < NC; c++) begin
                if (int'(update_provider_i) == c + 1) begin
                    ent_nxt[c].ctr = ctr_train(ent[c].ctr, update_taken_i);
                    // Useful only moves when alt disagreed
                    if (update_pred_taken_i != update_alt_taken_i) begin
                        ent_nxt[c].useful = u_step(ent[c].useful, correct);
                    end
                    we_t[c] = 1'b1;
                end
            end
            // Mispredict below the longest component
            if (mispred && (update_provider_i < 2'd2)) begin
                for (int c = 0; c < NC; c++) begin
                    if (c + 1 > int'(update_provider_i) && !found
                        && ent[c].useful == '0) begin
                        alloc[c] = 1'b1;
                        found    = 1'b1;
                    end
                end
                for (int c = 0; c < NC; c++) begin
                    if (c + 1 > int'(update_provider_i)) begin
                        if (alloc[c]) begin
                            ent_nxt[c].valid  = 1'b1;
                            ent_nxt[c].tag    = up_tag[c];
                            ent_nxt[c].ctr    = update_taken_i ?
                                `BPU_CTR_W'(`BPU_CTR_WEAK_T) : `BPU_CTR_W'(`BPU_CTR_WEAK_NT);
                            ent_nxt[c].useful = '0;
                            we_t[c]           = 1'b1;
                        end else if (!found) begin
                            // Age the blockers
                            ent_nxt[c].useful = u_step(ent[c].useful, 1'b0);
                            we_t[c]           = 1'b1;
                        end
                    end
                end
            end
        end
    end

    assign wr.we1     = we_t[0];
    assign wr.we2     = we_t[1];
    assign wr.wd_ent1 = ent_nxt[0];
    assign wr.wd_ent2 = ent_nxt[1];

    a_one_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(alloc))
        else $error("more than one allocation in one update");

    // Table writes only in an update cycle
    a_write_needs_update: assert property (@(posedge clk) disable iff (!rst_n)
        (wr.we_base || wr.we1 || wr.we2) |-> update_valid_i)
        else $error("table write without update_valid_i");

endmodule

//--- verilog/tage_predictor.sv
// TAGE direction predictor top, base plus two tagged components
// Prediction is registered, metadata must be returned at resolution
`timescale 1ns/1ps
`include "bpu_macros.svh"

module tage_predictor (
    input  logic                 clk,
    input  logic                 rst_n,
    // Lookup
    input  logic                 predict_req_i,
    input  logic [`BPU_PC_W-1:0] predict_pc_i,
    output logic                 predict_valid_o,
    output logic                 predict_taken_o,
    output logic [1:0]           predict_provider_o,
    output logic                 predict_alt_taken_o,
    // Resolution
    input  logic                 update_valid_i,
    input  logic [`BPU_PC_W-1:0] update_pc_i,
    input  logic                 update_taken_i,
    input  logic                 update_cond_i,
    input  logic [1:0]           update_provider_i,
    input  logic                 update_pred_taken_i,
    input  logic                 update_alt_taken_i
);

    bpu_lookup_if lk_if ();
    bpu_write_if  wr_if ();

    // History and hashing
    tage_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .update_valid_i (update_valid_i),
        .update_taken_i (update_taken_i),
        .predict_pc_i   (predict_pc_i),
        .update_pc_i    (update_pc_i),
        .lookup         (lk_if.decode)
    );

    // Tables and provider selection
    tage_execute u_execute (
        .clk                 (clk),
        .rst_n               (rst_n),
        .predict_req_i       (predict_req_i),
        .lookup              (lk_if.execute),
        .wr                  (wr_if.tables),
        .predict_valid_o     (predict_valid_o),
        .predict_taken_o     (predict_taken_o),
        .predict_provider_o  (predict_provider_o),
        .predict_alt_taken_o (predict_alt_taken_o)
    );

    // Training and allocation
    tage_result u_result (
        .clk                 (clk),
        .rst_n               (rst_n),
        .update_valid_i      (update_valid_i),
        .update_cond_i       (update_cond_i),
        .update_taken_i      (update_taken_i),
        .update_provider_i   (update_provider_i),
        .update_pred_taken_i (update_pred_taken_i),
        .update_alt_taken_i  (update_alt_taken_i),
        .wr                  (wr_if.policy)
    );

endmodule

//--- test/tage_ref_model.svh
// Reference TAGE model, lives inside the testbench module scope
// Non-speculative history, lowest free longer component allocates
`ifndef TAGE_REF_MODEL_SVH
`define TAGE_REF_MODEL_SVH

int          m_base [1 << `BPU_BASE_IDX_W];
bit          m_vld  [2][1 << `BPU_TAG_IDX_W];
int          m_tag  [2][1 << `BPU_TAG_IDX_W];
int          m_ctr  [2][1 << `BPU_TAG_IDX_W];
int          m_u    [2][1 << `BPU_TAG_IDX_W];
logic [11:0] m_ghr;

task automatic model_reset();
    m_ghr = '0;
    foreach (m_base[i]) begin
        m_base[i] = 1;
    end
    foreach (m_vld[c, i]) begin
        m_vld[c][i] = 1'b0;
        m_tag[c][i] = 0;
        m_ctr[c][i] = 0;
        m_u[c][i]   = 0;
    end
endtask

// Low len history bits, cut in w-bit slices and XORed together
function automatic int fold(input int len, input int w);
    int h;
    int r;
    h = int'(m_ghr) & ((1 << len) - 1);
    r = 0;
    while (h != 0) begin
        r = r ^ (h & ((1 << w) - 1));
        h = h >> w;
    end
    return r;
endfunction

function automatic int hist_len(input int c);
    return (c == 0) ? `BPU_HIST1_LEN : `BPU_HIST2_LEN;
endfunction

// PC[7:2] for the index, PC[15:8] for the tag
function automatic int m_idx(input logic [31:0] pc, input int c);
    return ((pc >> 2) & 63) ^ fold(hist_len(c), 6);
endfunction

function automatic int m_tagof(input logic [31:0] pc, input int c);
    return ((pc >> 8) & 255) ^ fold(hist_len(c), 8);
endfunction

function automatic int sat(input int v, input bit up, input int max);
    if (up) begin
        return (v < max) ? v + 1 : v;
    end
    return (v > 0) ? v - 1 : v;
endfunction

// Scan short to long, each hit pushes the old provider to alternate
task automatic model_predict(input logic [31:0] pc, output bit taken,
                             output int prov, output bit alt);
    int i;
    taken = m_base[(pc >> 2) & 255] >= 2;
    alt   = taken;
    prov  = 0;
    for (int c = 0; c < 2; c++) begin
        i = m_idx(pc, c);
        if (m_vld[c][i] && m_tag[c][i] == m_tagof(pc, c)) begin
            alt   = taken;
            taken = m_ctr[c][i] >= 4;
            prov  = c + 1;
        end
    end
endtask

task automatic model_update(input logic [31:0] pc, input bit taken, input bit cond,
                            input int prov, input bit pred, input bit alt);
    int idx [2];
    int b;
    int pick;
    b = (pc >> 2) & 255;
    for (int c = 0; c < 2; c++) begin
        idx[c] = m_idx(pc, c);
    end
    if (cond) begin
        if (prov == 0) begin
            m_base[b] = sat(m_base[b], taken, 3);
        end else begin
            m_ctr[prov-1][idx[prov-1]] = sat(m_ctr[prov-1][idx[prov-1]], taken, 7);
            // Useful moves only when alternate disagreed
            if (pred != alt) begin
                m_u[prov-1][idx[prov-1]] = sat(m_u[prov-1][idx[prov-1]], pred == taken, 3);
            end
        end
        if (pred != taken && prov < 2) begin
            pick = -1;
            for (int c = prov; c < 2; c++) begin
                if (pick < 0 && m_u[c][idx[c]] == 0) begin
                    pick = c;
                end
            end
            if (pick >= 0) begin
                m_vld[pick][idx[pick]] = 1'b1;
                m_tag[pick][idx[pick]] = m_tagof(pc, pick);
                m_ctr[pick][idx[pick]] = taken ? 4 : 3;
                m_u[pick][idx[pick]]   = 0;
            end else begin
                for (int c = prov; c < 2; c++) begin
                    m_u[c][idx[c]] = sat(m_u[c][idx[c]], 1'b0, 3);
                end
            end
        end
    end
    // Shift last so hashing above used the old history
    m_ghr = {m_ghr[10:0], taken};
endtask

`endif

//--- test/tb_tage_predictor.sv
// Seeded random branch stream checked against the reference model
// Update metadata is taken from DUT outputs after they are checked
`timescale 1ns/1ps
`include "bpu_macros.svh"

module tb_tage_predictor;

    localparam int PERIOD   = 100;
    localparam int N_BR     = 2000;
    localparam int N_PC     = 16;
    localparam int BURST    = 8;
    localparam int N_BURSTS = N_BR / 200 + 1;
    localparam int LIMIT    = (N_BR * 4 + N_BURSTS * (BURST + 4) + 50) * PERIOD;

    logic        clk;
    logic        rst_n;
    logic        predict_req_i;
    logic [31:0] predict_pc_i;
    logic        predict_valid_o;
    logic        predict_taken_o;
    logic [1:0]  predict_provider_o;
    logic        predict_alt_taken_o;
    logic        update_valid_i;
    logic [31:0] update_pc_i;
    logic        update_taken_i;
    logic        update_cond_i;
    logic [1:0]  update_provider_i;
    logic        update_pred_taken_i;
    logic        update_alt_taken_i;

    `include "tage_ref_model.svh"

    logic [31:0] pc_pool [N_PC];
    int          occ     [N_PC];
    int          seen    [3];

    tage_predictor dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .predict_req_i       (predict_req_i),
        .predict_pc_i        (predict_pc_i),
        .predict_valid_o     (predict_valid_o),
        .predict_taken_o     (predict_taken_o),
        .predict_provider_o  (predict_provider_o),
        .predict_alt_taken_o (predict_alt_taken_o),
        .update_valid_i      (update_valid_i),
        .update_pc_i         (update_pc_i),
        .update_taken_i      (update_taken_i),
        .update_cond_i       (update_cond_i),
        .update_provider_i   (update_provider_i),
        .update_pred_taken_i (update_pred_taken_i),
        .update_alt_taken_i  (update_alt_taken_i)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT);
        $display("timeout: branch stream did not finish within %0d ns", LIMIT);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Strobes drop every cycle unless driven again
    task automatic next_slot();
        @(posedge clk);
        #1;
        predict_req_i  = 1'b0;
        update_valid_i = 1'b0;
    endtask

    task automatic check_pred(input bit t, input int p, input bit a);
        check_val("predict_valid_o", predict_valid_o, 1);
        check_val("predict_taken_o", predict_taken_o, t);
        check_val("predict_provider_o", predict_provider_o, p);
        check_val("predict_alt_taken_o", predict_alt_taken_o, a);
        seen[p]++;
    endtask

    task automatic drive_update(input logic [31:0] pc, input bit t, input bit c,
                                input int p, input bit pt, input bit at);
        update_valid_i      = 1'b1;
        update_pc_i         = pc;
        update_taken_i      = t;
        update_cond_i       = c;
        update_provider_i   = 2'(p);
        update_pred_taken_i = pt;
        update_alt_taken_i  = at;
        model_update(pc, t, c, p, pt, at);
    endtask

    // Always taken, alternating, period three, or random per PC
    function automatic bit next_outcome(input int k);
        bit t;
        case (k % 4)
            0: t = 1'b1;
            1: t = (occ[k] % 2) == 0;
            2: t = (occ[k] % 3) != 2;
            default: t = ($urandom % 2) == 1;
        endcase
        occ[k]++;
        return t;
    endfunction

    // Back-to-back lookups, each checked one cycle after its request
    task automatic run_burst();
        bit          t_q [$];
        int          p_q [$];
        bit          a_q [$];
        bit          t;
        int          p;
        bit          a;
        logic [31:0] pc;
        for (int b = 0; b <= BURST; b++) begin
            if (b > 0) begin
                check_pred(t_q.pop_front(), p_q.pop_front(), a_q.pop_front());
            end
            if (b < BURST) begin
                pc            = pc_pool[$urandom % N_PC];
                predict_req_i = 1'b1;
                predict_pc_i  = pc;
                model_predict(pc, t, p, a);
                t_q.push_back(t);
                p_q.push_back(p);
                a_q.push_back(a);
            end
            next_slot();
        end
        check_val("predict_valid_o", predict_valid_o, 0);
    endtask

    initial begin
        bit          t_exp;
        int          p_exp;
        bit          a_exp;
        int          k;
        bit          pend;
        logic [31:0] pc;
        logic [31:0] pend_pc;
        bit          pend_t;
        bit          pend_c;
        int          pend_p;
        bit          pend_pt;
        bit          pend_at;
        void'($urandom(32'hd6bca0ea));
        rst_n               = 1'b0;
        predict_req_i       = 1'b0;
        predict_pc_i        = '0;
        update_valid_i      = 1'b0;
        update_pc_i         = '0;
        update_taken_i      = 1'b0;
        update_cond_i       = 1'b0;
        update_provider_i   = '0;
        update_pred_taken_i = 1'b0;
        update_alt_taken_i  = 1'b0;
        model_reset();
        for (int i = 0; i < N_PC; i++) begin
            pc_pool[i] = $urandom & 32'h0000_fffc;
            occ[i]     = 0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_val("predict_valid_o", predict_valid_o, 0);
        // Cold tables, base provides not-taken
        run_burst();
        pend = 1'b0;
        for (int n = 0; n < N_BR; n++) begin
            if (n % 200 == 199) begin
                if (pend) begin
                    drive_update(pend_pc, pend_t, pend_c, pend_p, pend_pt, pend_at);
                    pend = 1'b0;
                    next_slot();
                end
                run_burst();
            end
            k             = $urandom % N_PC;
            pc            = pc_pool[k];
            predict_req_i = 1'b1;
            predict_pc_i  = pc;
            // Predict first, a same-cycle update lands after this lookup
            model_predict(pc, t_exp, p_exp, a_exp);
            if (pend) begin
                drive_update(pend_pc, pend_t, pend_c, pend_p, pend_pt, pend_at);
                pend = 1'b0;
            end
            next_slot();
            check_pred(t_exp, p_exp, a_exp);
            pend_c  = ($urandom % 8) != 0;
            // Unconditional branches resolve taken
            pend_t  = pend_c ? next_outcome(k) : 1'b1;
            pend_pc = pc;
            pend_p  = predict_provider_o;
            pend_pt = predict_taken_o;
            pend_at = predict_alt_taken_o;
            if (($urandom % 4) == 0 && n < N_BR - 1) begin
                pend = 1'b1;
            end else begin
                drive_update(pend_pc, pend_t, pend_c, pend_p, pend_pt, pend_at);
                next_slot();
                check_val("predict_valid_o", predict_valid_o, 0);
            end
        end
        // Mispredictions must have grown the provider past base
        check_val("component 1 provider seen", seen[1] != 0, 1);
        check_val("component 2 provider seen", seen[2] != 0, 1);
        $display("TEST OK");
        $finish;
    end

endmodule

//--- tage_predictor.f
+incdir+verilog
+incdir+test
verilog/bpu_pkg.sv
verilog/bpu_if.sv
verilog/tage_decode.sv
verilog/tage_execute.sv
verilog/tage_result.sv
verilog/tage_predictor.sv
test/tb_tage_predictor.sv
